// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module tb_eg_top

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_eg_top -Mdir obj_dir
	./obj_dir/Vtb_eg_top | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// File: eg_attenuator.sv
`timescale 1ns/1ps
`include "eg_params.svh"

module eg_attenuator
	import eg_pkg::*;
	(
	input  logic       mclk_i,
	input  logic       arst_n_i,
	input  eg_level_t  level_i,
	input  logic [6:0] tl_i,
	input  logic [1:0] ams_i,
	input  logic [5:0] lfo_am_i,
	output eg_level_t  eg_out_o
	);

	logic [6:0]  am;
	logic [11:0] sum;

	// AM depth.
	always_comb
	begin
		case (ams_i)
		2'd0:    am = 7'h00;
		2'd1:    am = {3'b000, lfo_am_i[5:2]};
		2'd2:    am = {1'b0, lfo_am_i};
		default: am = {lfo_am_i, 1'b0};
		endcase
	end

	assign sum = {2'b00, level_i}
		+ ({5'h00, tl_i} << `EG_TL_SHIFT)
		+ {5'h00, am};

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			eg_out_o <= `EG_MAX_LEVEL;
		else if (sum > {2'b00, `EG_MAX_LEVEL})
			eg_out_o <= `EG_MAX_LEVEL; // Saturate.
		else
			eg_out_o <= sum[9:0];
	end

endmodule

// File: eg_checker.sv
`timescale 1ns/1ps
`include "eg_params.svh"

module eg_checker
	import eg_pkg::*;
	(
	input logic       mclk_i,
	input logic       arst_n_i,
	input logic [6:0] tl_i,
	input logic [1:0] ams_i,
	input logic [5:0] lfo_am_i,
	input eg_state_e  rate_sel_o,
	input logic       pg_reset_o,
	input eg_level_t  eg_level_o,
	input eg_level_t  eg_out_o
	);

	int unsigned fail_count = 0; // Failed assertions so far.

	// Saturated sum of level, eight times tl and the AM depth.
	function automatic logic [9:0] att_sum(logic [9:0] lvl, logic [6:0] tl,
		logic [1:0] ams, logic [5:0] lfo);
		int am;
		int total;
		am = (ams == 2'd0) ? 0 : (ams == 2'd1) ? lfo / 4 : (ams == 2'd2) ? lfo : lfo * 2;
		total = lvl + tl * 8 + am;
		return (total > 1023) ? 10'h3ff : total[9:0];
	endfunction

	a_reset_values: assert property (@(posedge mclk_i) !arst_n_i |=>
		eg_out_o == `EG_MAX_LEVEL && eg_level_o == `EG_MAX_LEVEL
		&& rate_sel_o == EG_RELEASE && !pg_reset_o)
		else
		begin
			$error("reset values wrong");
			fail_count++;
		end

	a_pg_one_cycle: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		pg_reset_o |=> !pg_reset_o)
		else
		begin
			$error("pg_reset_o longer than one cycle");
			fail_count++;
		end

	a_pg_attack: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		pg_reset_o |-> rate_sel_o == EG_ATTACK)
		else
		begin
			$error("rate select not attack with phase reset");
			fail_count++;
		end

	a_out_rule: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		1'b1 |=> eg_out_o == att_sum($past(eg_level_o), $past(tl_i), $past(ams_i),
		$past(lfo_am_i)))
		else
		begin
			$error("eg_out_o does not follow its inputs");
			fail_count++;
		end

	// Outside attack the attenuation only grows.
	a_no_decrease: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		(rate_sel_o != EG_ATTACK && $past(rate_sel_o) != EG_ATTACK)
		|-> eg_level_o >= $past(eg_level_o))
		else
		begin
			$error("eg_level_o decreased outside attack");
			fail_count++;
		end

endmodule

bind eg_top eg_checker checker_i
	(
	.mclk_i     (mclk_i),
	.arst_n_i   (arst_n_i),
	.tl_i       (tl_i),
	.ams_i      (ams_i),
	.lfo_am_i   (lfo_am_i),
	.rate_sel_o (rate_sel_o),
	.pg_reset_o (pg_reset_o),
	.eg_level_o (eg_level_o),
	.eg_out_o   (eg_out_o)
	);

// File: eg_key_ctrl.sv
`timescale 1ns/1ps

module eg_key_ctrl
	(
	input  logic mclk_i,
	input  logic arst_n_i,
	input  logic sample_i,
	input  logic kon_i,
	output logic kon_q_o,
	output logic kon_event_o,
	output logic koff_event_o,
	output logic pg_reset_o
	);

	logic kon_rise;
	logic kon_fall;

	// Edges are seen against the key state of the previous sample.
	assign kon_rise = sample_i & kon_i & ~kon_q_o;
	assign kon_fall = sample_i & ~kon_i & kon_q_o;

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			kon_q_o      <= 1'b0;
			kon_event_o  <= 1'b0;
			koff_event_o <= 1'b0;
		end
		else
		begin
			if (sample_i)
				kon_q_o <= kon_i;
			kon_event_o  <= kon_rise;
			koff_event_o <= kon_fall;
		end
	end

	assign pg_reset_o = kon_event_o; // Phase restarts on every key-on.

endmodule

// File: eg_level.sv
`timescale 1ns/1ps
`include "eg_params.svh"

module eg_level
	import eg_pkg::*;
	(
	input  logic       mclk_i,
	input  logic       arst_n_i,
	eg_step_if.dst     step,
	input  logic       kon_q_i,
	input  logic       kon_event_i,
	input  logic       koff_event_i,
	input  logic [3:0] sl_i,
	output eg_state_e  state_o,
	output eg_level_t  level_o
	);

	eg_state_e state_q;
	eg_level_t level_q;
	eg_level_t add_lin;
	eg_level_t add_exp;
	logic      zr_reach;
	logic      sl_reach;
	logic      quiet;
	logic      step_en;

	assign zr_reach = level_q == '0;
	assign sl_reach = (level_q[9:5] == {sl_i, 1'b0}) & ~level_q[4];
	assign quiet    = level_q[9:4] == `EG_QUIET_HI;
	assign step_en  = step.rate_nz;

	// ------------------------------------------------------------------------
	// Step sizes
	// ------------------------------------------------------------------------

	assign add_lin = {6'h00, step.inc}; // 1, 2, 4 or 8.

	// Adding ~(level >> n) subtracts (level >> n) + 1.
	always_comb
	begin
		add_exp = '0;
		if (step.inc[0])
			add_exp = add_exp | ~(level_q >> 4);
		if (step.inc[1])
			add_exp = add_exp | ~(level_q >> 3);
		if (step.inc[2])
			add_exp = add_exp | ~(level_q >> 2);
		if (step.inc[3])
			add_exp = add_exp | ~(level_q >> 1);
	end

	// ------------------------------------------------------------------------
	// State and level
	// ------------------------------------------------------------------------

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= EG_RELEASE;
			level_q <= `EG_MAX_LEVEL;
		end
		else if (kon_event_i)
		begin
			state_q <= EG_ATTACK;
			if (step.attack_fast)
				level_q <= '0; // Instant attack.
		end
		else if (koff_event_i)
			state_q <= EG_RELEASE;
		else if (step.step_strobe)
		begin
			case (state_q)
			EG_ATTACK:
			begin
				if (zr_reach)
					state_q <= EG_DECAY;
				else if (step.attack_fast)
					level_q <= '0;
				else if (kon_q_i & step_en)
					level_q <= level_q + add_exp;
			end
			EG_DECAY:
			begin
				if (quiet)
					level_q <= `EG_MAX_LEVEL;
				else if (sl_reach)
					state_q <= EG_SUSTAIN;
				else if (step_en)
					level_q <= level_q + add_lin;
			end
			default:
			begin
				if (quiet)
					level_q <= `EG_MAX_LEVEL; // Mute.
				else if (step_en)
					level_q <= level_q + add_lin;
			end
			endcase
		end
	end

	// Attack shows up already in the key-on cycle, like the chip's rate select.
	assign state_o = kon_event_i ? EG_ATTACK : state_q;
	assign level_o = level_q;

endmodule

// File: eg_params.svh
`ifndef EG_PARAMS_SVH
`define EG_PARAMS_SVH

// Envelope level, 0 is loudest.
`define EG_LEVEL_W 10
`define EG_MAX_LEVEL 10'h3ff

// Level[9:4] pattern treated as silence.
`define EG_QUIET_HI 6'h3f

`define EG_TIMER_W 12

// Effective rate after key scaling.
`define EG_RATE_W 6
`define EG_RATE_MAX_FAST 6'd62

// Total level is in 0.75 dB steps, the envelope in 0.09375 dB steps.
`define EG_TL_SHIFT 3

`endif

// File: eg_pkg.sv
`include "eg_params.svh"

package eg_pkg;

	// Envelope phase, also used as the rate select towards the register file.
	typedef enum logic [1:0]
	{
		EG_ATTACK  = 2'd0,
		EG_DECAY   = 2'd1,
		EG_SUSTAIN = 2'd2,
		EG_RELEASE = 2'd3
	} eg_state_e;

	// Attenuation.
	typedef logic [`EG_LEVEL_W-1:0] eg_level_t;

	// Rate after key scaling and clamping.
	typedef logic [`EG_RATE_W-1:0] eg_rate_t;

endpackage

// File: eg_rate_step.sv
`timescale 1ns/1ps
`include "eg_params.svh"

module eg_rate_step
	import eg_pkg::*;
	(
	input  logic       mclk_i,
	input  logic       arst_n_i,
	input  logic       tick_i,
	input  logic [3:0] cnt_shift_i,
	input  logic [4:0] rate_i,
	input  logic [4:0] kcode_i,
	input  logic [1:0] ks_i,
	eg_step_if.src     step
	);

	logic [4:0] ks_add;
	logic [6:0] rate_sum;
	eg_rate_t   rate_eff;
	logic [3:0] shift_sum;
	logic       rate_ls12;
	logic       step_low;
	logic       dbl;
	logic       r12;
	logic       r13;
	logic       r14;
	logic       r15;
	logic [3:0] inc_d;

	// ------------------------------------------------------------------------
	// Effective rate
	// ------------------------------------------------------------------------

	assign ks_add   = kcode_i >> (2'd3 - ks_i);
	assign rate_sum = {1'b0, rate_i, 1'b0} + {2'b00, ks_add};

	always_comb
	begin
		if (rate_i == 5'd0)
			rate_eff = '0;
		else if (rate_sum[6])
			rate_eff = 6'h3f;
		else
			rate_eff = rate_sum[5:0];
	end

	// ------------------------------------------------------------------------
	// Increment select
	// ------------------------------------------------------------------------

	assign shift_sum = rate_eff[5:2] + cnt_shift_i; // Wraps, as in the chip.
	assign rate_ls12 = rate_eff[5:4] != 2'b11;

	// Slow rates step at most once per tick, picked by the timer shift.
	assign step_low = rate_ls12 & ((shift_sum == 4'hc)
		| (shift_sum == 4'hd & rate_eff[1])
		| (shift_sum == 4'he & rate_eff[0]));

	// Fast rates alternate between two step sizes.
	assign dbl = ~((cnt_shift_i[0] & rate_eff[1])
		| (cnt_shift_i[1:0] == 2'd0 & rate_eff[1:0] == 2'd1)
		| (cnt_shift_i[1:0] == 2'd1 & rate_eff[1:0] == 2'd3));

	assign r12 = rate_eff[5:2] == 4'hc;
	assign r13 = rate_eff[5:2] == 4'hd;
	assign r14 = rate_eff[5:2] == 4'he;
	assign r15 = rate_eff[5:2] == 4'hf;

	assign inc_d[0] = step_low | (~dbl & r12);
	assign inc_d[1] = dbl ? r12 : r13;
	assign inc_d[2] = dbl ? r13 : r14;
	assign inc_d[3] = (dbl & r14) | r15;

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			step.step_strobe <= 1'b0;
			step.attack_fast <= 1'b0;
		end
		else
		begin
			step.step_strobe <= tick_i;
			step.attack_fast <= rate_eff >= `EG_RATE_MAX_FAST;
		end
	end

	always_ff @(posedge mclk_i)
	begin
		if (tick_i)
		begin
			step.inc     <= inc_d;
			step.rate_nz <= rate_eff != '0;
		end
	end

endmodule

// File: eg_step_if.sv
`timescale 1ns/1ps

// Step decision from the rate unit to the level unit.
// inc and rate_nz only mean something while step_strobe is high.
// attack_fast is refreshed every cycle so a key-on can use it too.
interface eg_step_if;

	logic       step_strobe;  // One cycle per envelope step.
	logic [3:0] inc;          // Bit n selects an add of 1 << n.
	logic       attack_fast;  // Effective rate 62 or 63.
	logic       rate_nz;

	modport src
		(
		output step_strobe,
		output inc,
		output attack_fast,
		output rate_nz
		);

	modport dst
		(
		input step_strobe,
		input inc,
		input attack_fast,
		input rate_nz
		);

endinterface

// File: eg_timer.sv
`timescale 1ns/1ps
`include "eg_params.svh"

module eg_timer
	(
	input  logic       mclk_i,
	input  logic       arst_n_i,
	input  logic       sample_i,
	output logic       tick_o,
	output logic [3:0] cnt_shift_o
	);

	logic [1:0]             sub_cnt;
	logic [`EG_TIMER_W-1:0] timer_q;
	logic [`EG_TIMER_W-1:0] timer_nxt;
	logic [3:0]             shift_nxt;
	logic                   wrap;

	assign wrap = sample_i & (sub_cnt == 2'd2); // Every third sample.

	always_comb
	begin
		timer_nxt = timer_q + 1'b1;
		if (timer_nxt == '0)
			timer_nxt = 1; // Zero never shows up.
		// Lowest set bit, encoded as its position plus one.
		shift_nxt = 4'd0;
		for (int i = `EG_TIMER_W - 1; i >= 0; i--)
		begin
			if (timer_nxt[i])
				shift_nxt = 4'(i + 1);
		end
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			sub_cnt     <= 2'd0;
			timer_q     <= '0;
			tick_o      <= 1'b0;
			cnt_shift_o <= 4'd0;
		end
		else
		begin
			tick_o <= wrap;
			if (wrap)
			begin
				sub_cnt     <= 2'd0;
				timer_q     <= timer_nxt;
				cnt_shift_o <= shift_nxt;
			end
			else if (sample_i)
				sub_cnt <= sub_cnt + 2'd1;
		end
	end

endmodule

// File: eg_top.sv
`timescale 1ns/1ps

module eg_top
	import eg_pkg::*;
	(
	input  logic       mclk_i,
	input  logic       arst_n_i,
	input  logic       sample_i,
	input  logic       kon_i,
	input  logic [4:0] rate_i,
	input  logic [4:0] kcode_i,
	input  logic [1:0] ks_i,
	input  logic [3:0] sl_i,
	input  logic [6:0] tl_i,
	input  logic [1:0] ams_i,
	input  logic [5:0] lfo_am_i,
	output eg_state_e  rate_sel_o,
	output logic       pg_reset_o,
	output eg_level_t  eg_level_o,
	output eg_level_t  eg_out_o
	);

	logic       tick;
	logic [3:0] cnt_shift;
	logic       kon_q;
	logic       kon_event;
	logic       koff_event;

	eg_step_if step_if ();

	eg_timer timer_i
		(
		.mclk_i      (mclk_i),
		.arst_n_i    (arst_n_i),
		.sample_i    (sample_i),
		.tick_o      (tick),
		.cnt_shift_o (cnt_shift)
		);

	eg_rate_step rate_step_i
		(
		.mclk_i      (mclk_i),
		.arst_n_i    (arst_n_i),
		.tick_i      (tick),
		.cnt_shift_i (cnt_shift),
		.rate_i      (rate_i),
		.kcode_i     (kcode_i),
		.ks_i        (ks_i),
		.step        (step_if.src)
		);

	eg_key_ctrl key_ctrl_i
		(
		.mclk_i       (mclk_i),
		.arst_n_i     (arst_n_i),
		.sample_i     (sample_i),
		.kon_i        (kon_i),
		.kon_q_o      (kon_q),
		.kon_event_o  (kon_event),
		.koff_event_o (koff_event),
		.pg_reset_o   (pg_reset_o)
		);

	eg_level level_i
		(
		.mclk_i       (mclk_i),
		.arst_n_i     (arst_n_i),
		.step         (step_if.dst),
		.kon_q_i      (kon_q),
		.kon_event_i  (kon_event),
		.koff_event_i (koff_event),
		.sl_i         (sl_i),
		.state_o      (rate_sel_o),
		.level_o      (eg_level_o)
		);

	eg_attenuator attenuator_i
		(
		.mclk_i   (mclk_i),
		.arst_n_i (arst_n_i),
		.level_i  (eg_level_o),
		.tl_i     (tl_i),
		.ams_i    (ams_i),
		.lfo_am_i (lfo_am_i),
		.eg_out_o (eg_out_o)
		);

endmodule

// File: project.f
+incdir+.
eg_pkg.sv
eg_step_if.sv
eg_timer.sv
eg_rate_step.sv
eg_key_ctrl.sv
eg_level.sv
eg_attenuator.sv
eg_top.sv
eg_checker.sv
tb_eg_top.sv

// File: tb_eg_top.sv
`timescale 1ns/1ps
`include "eg_params.svh"

module tb_eg_top
	import eg_pkg::*;
	();

	logic       mclk_i;
	logic       arst_n_i;
	logic       sample_i;
	logic       kon_i;
	logic [4:0] rate_i;
	logic [4:0] kcode_i;
	logic [1:0] ks_i;
	logic [1:0] ams_i;
	logic [3:0] sl_i;
	logic [6:0] tl_i;
	logic [5:0] lfo_am_i;
	eg_state_e  rate_sel_o;
	logic       pg_reset_o;
	eg_level_t  eg_level_o;
	eg_level_t  eg_out_o;

	logic [4:0]  ar_rate;
	logic [4:0]  d1_rate;
	logic [4:0]  d2_rate;
	logic [4:0]  rr_rate;
	int unsigned cyc;
	int errors;
	int tests;
	int test_err;
	int seed;

	eg_top eg_top_i (.*);

	initial
	begin
		mclk_i = 1'b0;
		forever #20 mclk_i = ~mclk_i;
	end

	// Sample strobe every fourth cycle and a rate picked by the current phase.
	always @(posedge mclk_i)
	begin
		#2;
		cyc = cyc + 1;
		sample_i = cyc[1:0] == 2'd0;
		case (rate_sel_o)
		EG_ATTACK:  rate_i = ar_rate;
		EG_DECAY:   rate_i = d1_rate;
		EG_SUSTAIN: rate_i = d2_rate;
		default:    rate_i = rr_rate;
		endcase
	end

	task automatic check_hex(input string name, input logic [11:0] got, input logic [11:0] exp);
		assert (got == exp)
		else
		begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_state(input eg_state_e s, input int limit);
		int n;
		n = 0;
		while (rate_sel_o != s && n < limit)
		begin
			@(negedge mclk_i);
			n++;
		end
		if (rate_sel_o != s)
		begin
			$display("Timeout: the envelope never reached %s", s.name());
			errors++;
		end
	endtask

	task automatic wait_level(input eg_level_t lvl, input int limit);
		int n;
		n = 0;
		while (eg_level_o != lvl && n < limit)
		begin
			@(negedge mclk_i);
			n++;
		end
		if (eg_level_o != lvl)
		begin
			$display("Timeout: the level never reached %h", lvl);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		int now_err;
		now_err = errors + int'(eg_top_i.checker_i.fail_count);
		tests++;
		$display("Test %0d %s: %s", tests, name, (now_err == test_err) ? "ok" : "failed");
		test_err = now_err;
	endtask

	// Expected attenuation from level, total level and AM depth.
	function automatic logic [9:0] expect_out(int lvl, int tl, int ams, int lfo);
		int am;
		int total;
		case (ams)
		0:       am = 0;
		1:       am = lfo >> 2;
		2:       am = lfo;
		default: am = lfo << 1;
		endcase
		total = lvl + (tl << 3) + am;
		return (total > 1023) ? 10'h3ff : total[9:0];
	endfunction

	initial
	begin
		int n;
		int lvl_r;
		int tl_r;
		int ams_r;
		int lfo_r;
		seed = $urandom(32'h3b0);
		arst_n_i = 1'b0;
		sample_i = 1'b0;
		kon_i    = 1'b0;
		cyc      = 0;
		errors   = 0;
		tests    = 0;
		test_err = 0;
		rate_i   = '0;
		kcode_i  = '0;
		ks_i     = '0;
		ams_i    = '0;
		sl_i     = '0;
		tl_i     = '0;
		lfo_am_i = '0;
		ar_rate  = 5'd31;
		d1_rate  = 5'd0;
		d2_rate  = 5'd0;
		rr_rate  = 5'd31;

		// ------------------------------------------------------------------------
		repeat (16)
		begin
			@(negedge mclk_i);
			check_hex("eg_out_o", eg_out_o, 12'h3ff);
			check_hex("eg_level_o", eg_level_o, 12'h3ff);
			check_hex("rate_sel_o", rate_sel_o, EG_RELEASE);
			check_hex("pg_reset_o", pg_reset_o, 0);
		end
		@(posedge mclk_i) #2 arst_n_i = 1'b1;
		@(negedge mclk_i);
		check_hex("eg_out_o", eg_out_o, 12'h3ff);
		check_hex("eg_level_o", eg_level_o, 12'h3ff);
		check_hex("rate_sel_o", rate_sel_o, EG_RELEASE);
		check_hex("pg_reset_o", pg_reset_o, 0);
		end_test("reset");

		// ------------------------------------------------------------------------
		ks_i = 2'd3;
		kcode_i = 5'd31;
		@(posedge mclk_i) #2 kon_i = 1'b1;
		n = 0;
		while (!pg_reset_o && n < 20)
		begin
			@(negedge mclk_i);
			n++;
		end
		if (!pg_reset_o)
		begin
			$display("Timeout: no phase reset after key-on");
			errors++;
		end
		check_hex("rate_sel_o", rate_sel_o, EG_ATTACK);
		@(negedge mclk_i);
		check_hex("pg_reset_o", pg_reset_o, 0);
		end_test("key-on pulse");

		check_hex("eg_level_o", eg_level_o, 0); // Instant attack.
		wait_state(EG_DECAY, 14); // One envelope step is twelve cycles.
		end_test("instant attack");

		// ------------------------------------------------------------------------
		wait_state(EG_SUSTAIN, 60);
		check_hex("eg_level_o", eg_level_o, 0);
		@(posedge mclk_i) #2 kon_i = 1'b0;
		wait_state(EG_RELEASE, 20);
		wait_level(`EG_MAX_LEVEL, 2000);
		ks_i    = 2'd0;
		kcode_i = 5'd0;
		sl_i    = 4'd4;
		d1_rate = 5'd24;
		d2_rate = 5'd24;
		@(posedge mclk_i) #2 kon_i = 1'b1;
		wait_state(EG_ATTACK, 20);
		wait_state(EG_SUSTAIN, 20000);
		check_hex("eg_level_o[9:5]", eg_level_o[9:5], 12'h8);
		repeat (200) @(negedge mclk_i);
		end_test("decay and sustain");

		// ------------------------------------------------------------------------
		repeat (20)
		begin
			@(posedge mclk_i) #2;
			tl_i = 7'($urandom % 128);
			lfo_am_i = 6'($urandom % 64);
			ams_i = 2'($urandom % 4);
			@(negedge mclk_i);
			lvl_r = 32'(eg_level_o);
			tl_r  = 32'(tl_i);
			ams_r = 32'(ams_i);
			lfo_r = 32'(lfo_am_i);
			@(negedge mclk_i);
			check_hex("eg_out_o", eg_out_o, expect_out(lvl_r, tl_r, ams_r, lfo_r));
		end
		end_test("output rule");

		// ------------------------------------------------------------------------
		rr_rate = 5'd26;
		@(posedge mclk_i) #2 kon_i = 1'b0;
		wait_state(EG_RELEASE, 20);
		wait_level(`EG_MAX_LEVEL, 60000);
		repeat (100) @(negedge mclk_i);
		check_hex("eg_level_o", eg_level_o, 12'h3ff);
		check_hex("rate_sel_o", rate_sel_o, EG_RELEASE);
		end_test("release");

		errors = errors + int'(eg_top_i.checker_i.fail_count);
		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
